// ==== source/rv_pkg.sv ====
//*********************************************************************
// Shared widths, RV64I opcode and funct constants, internal ALU codes,
// the instruction format union and the decode and writeback structs.
//*********************************************************************
`default_nettype none

package rv_pkg;

  localparam int XLEN      = 64;
  localparam int ILEN      = 32;
  localparam int REG_IDX_W = 5;
  localparam int NUM_REGS  = 1 << REG_IDX_W;
  localparam int SHAMT_W   = $clog2(XLEN);

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  localparam logic [2:0] F3_ADD = 3'b000;  // Also sub.
  localparam logic [2:0] F3_SLL = 3'b001;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_SRL = 3'b101;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;  // Selects sub in the OP group.

  typedef enum logic [3:0] {
    ALU_NONE = 4'd0,
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_JAL
  } alu_op_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // One instruction word seen through each encoding format.
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } inst_u;

  typedef struct packed {
    logic [XLEN-1:0]      pc;
    logic [ILEN-1:0]      inst;
    alu_op_e              alu_op;
    logic [REG_IDX_W-1:0] rd;
    logic                 rd_wen;
    logic [XLEN-1:0]      op1;
    logic [XLEN-1:0]      op2;
    logic [XLEN-1:0]      op3;  // Jump target for jal.
    logic                 illegal;
  } dec_op_t;

  typedef struct packed {
    logic [XLEN-1:0]      pc;
    logic [ILEN-1:0]      inst;
    logic [REG_IDX_W-1:0] rd;
    logic                 wen;
    logic [XLEN-1:0]      data;
    logic [XLEN-1:0]      next_pc;
    logic                 illegal;
  } wb_t;

endpackage

`default_nettype wire

// ==== source/id_decoder.sv ====
//*********************************************************************
// Combinational RV64I decoder with immediate generation and operands.
//*********************************************************************
`timescale 1ns/100ps
`default_nettype none

module id_decoder (
  input  wire rv_pkg::inst_u                i_inst,
  input  wire [rv_pkg::XLEN-1:0]            i_pc,
  input  wire [rv_pkg::XLEN-1:0]            i_rs1_data,
  input  wire [rv_pkg::XLEN-1:0]            i_rs2_data,
  output logic [rv_pkg::REG_IDX_W-1:0]      o_rs1,
  output logic [rv_pkg::REG_IDX_W-1:0]      o_rs2,
  output rv_pkg::dec_op_t                   o_dec
);
  import rv_pkg::*;

  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;
  alu_op_e         op_r;
  alu_op_e         op_i;

  assign imm_i = {{(XLEN-12){i_inst.i_fmt.imm_11_0[11]}}, i_inst.i_fmt.imm_11_0};
  assign imm_u = {{(XLEN-32){i_inst.u_fmt.imm_31_12[19]}}, i_inst.u_fmt.imm_31_12, 12'b0};
  assign imm_j = {{(XLEN-21){i_inst.j_fmt.imm_20}}, i_inst.j_fmt.imm_20,
                  i_inst.j_fmt.imm_19_12, i_inst.j_fmt.imm_11,
                  i_inst.j_fmt.imm_10_1, 1'b0};

  // Register-register group.
  always_comb begin
    op_r = ALU_NONE;
    if (i_inst.r_fmt.funct7 == F7_BASE) begin
      case (i_inst.r_fmt.funct3)
        F3_ADD:  op_r = ALU_ADD;
        F3_SLL:  op_r = ALU_SLL;
        F3_XOR:  op_r = ALU_XOR;
        F3_SRL:  op_r = ALU_SRL;
        F3_OR:   op_r = ALU_OR;
        F3_AND:  op_r = ALU_AND;
        default: op_r = ALU_NONE;
      endcase
    end else if (i_inst.r_fmt.funct7 == F7_ALT && i_inst.r_fmt.funct3 == F3_ADD) begin
      op_r = ALU_SUB;
    end
  end

  always_comb begin
    case (i_inst.i_fmt.funct3)
      F3_ADD:  op_i = ALU_ADD;
      F3_XOR:  op_i = ALU_XOR;
      F3_OR:   op_i = ALU_OR;
      F3_AND:  op_i = ALU_AND;
      F3_SLL:  op_i = (i_inst.i_fmt.imm_11_0[11:6] == '0) ? ALU_SLL : ALU_NONE;
      F3_SRL:  op_i = (i_inst.i_fmt.imm_11_0[11:6] == '0) ? ALU_SRL : ALU_NONE;
      default: op_i = ALU_NONE;
    endcase
  end

  always_comb begin
    o_dec        = '0;
    o_dec.pc     = i_pc;
    o_dec.inst   = i_inst;
    o_dec.rd     = i_inst.r_fmt.rd;  // The rd field sits at the same bits in every format.
    o_dec.alu_op = ALU_NONE;
    o_rs1        = '0;
    o_rs2        = '0;
    case (i_inst.r_fmt.opcode)
      OPC_OP: begin
        o_rs1        = i_inst.r_fmt.rs1;
        o_rs2        = i_inst.r_fmt.rs2;
        o_dec.alu_op = op_r;
        o_dec.op1    = i_rs1_data;
        o_dec.op2    = i_rs2_data;
      end
      OPC_OP_IMM: begin
        o_rs1        = i_inst.i_fmt.rs1;
        o_dec.alu_op = op_i;
        o_dec.op1    = i_rs1_data;
        o_dec.op2    = imm_i;
      end
      OPC_LUI: begin
        o_dec.alu_op = ALU_ADD;
        o_dec.op2    = imm_u;
      end
      OPC_AUIPC: begin
        o_dec.alu_op = ALU_ADD;
        o_dec.op1    = i_pc;
        o_dec.op2    = imm_u;
      end
      OPC_JAL: begin
        o_dec.alu_op = ALU_JAL;
        o_dec.op1    = i_pc;
        o_dec.op2    = XLEN'(4);  // Link value is pc + 4.
        o_dec.op3    = i_pc + imm_j;
      end
      default: ;
    endcase
    o_dec.illegal = (o_dec.alu_op == ALU_NONE);
    o_dec.rd_wen  = !o_dec.illegal;
  end

endmodule

`default_nettype wire

// ==== source/id_stage.sv ====
//*********************************************************************
// Decode stage holding the fetched pc and instruction until accepted.
//*********************************************************************
`timescale 1ns/100ps
`default_nettype none

module id_stage (
  input  wire                               clk,
  input  wire                               rst,
  input  wire                               i_fetch_req,
  input  wire [rv_pkg::XLEN-1:0]            i_fetch_pc,
  input  wire [rv_pkg::ILEN-1:0]            i_fetch_inst,
  input  wire                               i_dec_ack,
  input  wire [rv_pkg::XLEN-1:0]            i_rs1_data,
  input  wire [rv_pkg::XLEN-1:0]            i_rs2_data,
  output logic [rv_pkg::REG_IDX_W-1:0]      o_rs1,
  output logic [rv_pkg::REG_IDX_W-1:0]      o_rs2,
  output logic                              o_dec_req,
  output rv_pkg::dec_op_t                   o_dec
);
  import rv_pkg::*;

  logic [XLEN-1:0] pc_q;
  inst_u           inst_q;
  dec_op_t         dec_raw;
  logic            dec_hs;

  assign dec_hs = o_dec_req & i_dec_ack;

  always_ff @(posedge clk) begin
    if (rst) begin
      o_dec_req <= 1'b0;
    end else if (i_fetch_req) begin  // A new strobe wins over the handshake.
      o_dec_req <= 1'b1;
    end else if (dec_hs) begin
      o_dec_req <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (i_fetch_req) begin
      pc_q   <= i_fetch_pc;
      inst_q <= i_fetch_inst;
    end
  end

  id_decoder u_decoder (
    .i_inst     (inst_q),
    .i_pc       (pc_q),
    .i_rs1_data (i_rs1_data),
    .i_rs2_data (i_rs2_data),
    .o_rs1      (o_rs1),
    .o_rs2      (o_rs2),
    .o_dec      (dec_raw)
  );

  assign o_dec = o_dec_req ? dec_raw : '0;

  // A pending instruction must never be overwritten before execute takes it.
  a_no_overrun: assert property (@(posedge clk) disable iff (rst)
    i_fetch_req |-> (!o_dec_req || i_dec_ack))
    else $error("Fetch strobe while decode request is pending.");

endmodule

`default_nettype wire

// ==== source/reg_file.sv ====
//*********************************************************************
// Register file, 32 x 64 bits, two read ports and one write port.
//*********************************************************************
`timescale 1ns/100ps
`default_nettype none

module reg_file (
  input  wire                               clk,
  input  wire                               rst,
  input  wire [rv_pkg::REG_IDX_W-1:0]       i_rs1,
  input  wire [rv_pkg::REG_IDX_W-1:0]       i_rs2,
  output logic [rv_pkg::XLEN-1:0]           o_rs1_data,
  output logic [rv_pkg::XLEN-1:0]           o_rs2_data,
  input  wire                               i_wen,
  input  wire [rv_pkg::REG_IDX_W-1:0]       i_rd,
  input  wire [rv_pkg::XLEN-1:0]            i_wdata
);
  import rv_pkg::*;

  logic [XLEN-1:0] regs [1:NUM_REGS-1];  // x0 has no storage.

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && i_rd != '0) begin
      regs[i_rd] <= i_wdata;
    end
  end

  assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
  assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

  // Execute is expected to drop writes to x0 before they get here.
  a_no_x0_write: assert property (@(posedge clk) disable iff (rst)
    i_wen |-> (i_rd != '0))
    else $error("Register file write targets x0.");

endmodule

`default_nettype wire

// ==== source/ex_stage.sv ====
//*********************************************************************
// Execute and writeback stage with ALU, next pc and result register.
//*********************************************************************
`timescale 1ns/100ps
`default_nettype none

module ex_stage (
  input  wire                               clk,
  input  wire                               rst,
  input  wire                               i_stall,
  input  wire                               i_dec_req,
  input  wire rv_pkg::dec_op_t              i_dec,
  output logic                              o_dec_ack,
  output logic                              o_rf_wen,
  output logic [rv_pkg::REG_IDX_W-1:0]      o_rf_rd,
  output logic [rv_pkg::XLEN-1:0]           o_rf_wdata,
  output logic                              o_wb_valid,
  output rv_pkg::wb_t                       o_wb
);
  import rv_pkg::*;

  logic               dec_hs;
  logic [SHAMT_W-1:0] shamt;
  logic [XLEN-1:0]    result;
  logic [XLEN-1:0]    next_pc;

  assign o_dec_ack = i_dec_req & ~i_stall;
  assign dec_hs    = i_dec_req & o_dec_ack;
  assign shamt     = i_dec.op2[SHAMT_W-1:0];

  always_comb begin
    case (i_dec.alu_op)
      ALU_ADD, ALU_JAL: result = i_dec.op1 + i_dec.op2;
      ALU_SUB:          result = i_dec.op1 - i_dec.op2;
      ALU_AND:          result = i_dec.op1 & i_dec.op2;
      ALU_OR:           result = i_dec.op1 | i_dec.op2;
      ALU_XOR:          result = i_dec.op1 ^ i_dec.op2;
      ALU_SLL:          result = i_dec.op1 << shamt;
      ALU_SRL:          result = i_dec.op1 >> shamt;
      default:          result = '0;
    endcase
  end

  assign next_pc = (i_dec.alu_op == ALU_JAL) ? i_dec.op3 : i_dec.pc + XLEN'(4);

  // The write lands at the handshake edge so the next instruction sees it.
  assign o_rf_wen   = dec_hs & i_dec.rd_wen & (i_dec.rd != '0);
  assign o_rf_rd    = i_dec.rd;
  assign o_rf_wdata = result;

  always_ff @(posedge clk) begin
    if (rst) begin
      o_wb_valid <= 1'b0;
    end else begin
      o_wb_valid <= dec_hs;
    end
  end

  always_ff @(posedge clk) begin
    if (dec_hs) begin
      o_wb.pc      <= i_dec.pc;
      o_wb.inst    <= i_dec.inst;
      o_wb.rd      <= i_dec.rd;
      o_wb.wen     <= i_dec.rd_wen;
      o_wb.data    <= result;
      o_wb.next_pc <= next_pc;
      o_wb.illegal <= i_dec.illegal;
    end
  end

  // Decode must hold its request and payload while execute stalls.
  a_stall_stable: assert property (@(posedge clk) disable iff (rst)
    (i_dec_req && i_stall) |=> (i_dec_req && $stable(i_dec)))
    else $error("Decoded instruction changed during stall.");

endmodule

`default_nettype wire

// ==== source/core_top.sv ====
//*********************************************************************
// Top level joining decode, register file and execute.
//*********************************************************************
`timescale 1ns/100ps
`default_nettype none

module core_top (
  input  wire                               clk,
  input  wire                               rst,
  input  wire                               i_fetch_req,
  input  wire [rv_pkg::XLEN-1:0]            i_fetch_pc,
  input  wire [rv_pkg::ILEN-1:0]            i_fetch_inst,
  input  wire                               i_stall,
  output logic                              o_busy,
  output logic                              o_wb_valid,
  output rv_pkg::wb_t                       o_wb
);
  import rv_pkg::*;

  wire                 dec_req;
  wire                 dec_ack;
  wire dec_op_t        dec;
  wire [REG_IDX_W-1:0] rs1;
  wire [REG_IDX_W-1:0] rs2;
  wire [XLEN-1:0]      rs1_data;
  wire [XLEN-1:0]      rs2_data;
  wire                 rf_wen;
  wire [REG_IDX_W-1:0] rf_rd;
  wire [XLEN-1:0]      rf_wdata;

  assign o_busy = dec_req;  // Busy while an instruction waits in decode.

  id_stage u_id_stage (
    .clk          (clk),
    .rst          (rst),
    .i_fetch_req  (i_fetch_req),
    .i_fetch_pc   (i_fetch_pc),
    .i_fetch_inst (i_fetch_inst),
    .i_dec_ack    (dec_ack),
    .i_rs1_data   (rs1_data),
    .i_rs2_data   (rs2_data),
    .o_rs1        (rs1),
    .o_rs2        (rs2),
    .o_dec_req    (dec_req),
    .o_dec        (dec)
  );

  reg_file u_reg_file (
    .clk        (clk),
    .rst        (rst),
    .i_rs1      (rs1),
    .i_rs2      (rs2),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data),
    .i_wen      (rf_wen),
    .i_rd       (rf_rd),
    .i_wdata    (rf_wdata)
  );

  ex_stage u_ex_stage (
    .clk        (clk),
    .rst        (rst),
    .i_stall    (i_stall),
    .i_dec_req  (dec_req),
    .i_dec      (dec),
    .o_dec_ack  (dec_ack),
    .o_rf_wen   (rf_wen),
    .o_rf_rd    (rf_rd),
    .o_rf_wdata (rf_wdata),
    .o_wb_valid (o_wb_valid),
    .o_wb       (o_wb)
  );

endmodule

`default_nettype wire

// ==== verification/tb_core.sv ====
//*********************************************************************
// Testbench for the decode and execute slice with a reference model.
//*********************************************************************
`timescale 1ns/100ps
`default_nettype none

module tb_core;
  import rv_pkg::*;

  localparam int NUM_INSTS    = 400;
  localparam int CLK_PERIOD   = 4;
  localparam int LIMIT_CYCLES = NUM_INSTS * 20 + 200;

  logic            clk;
  logic            rst;
  logic            i_fetch_req;
  logic [XLEN-1:0] i_fetch_pc;
  logic [ILEN-1:0] i_fetch_inst;
  logic            i_stall;
  logic            o_busy;
  logic            o_wb_valid;
  wb_t             o_wb;

  int              seed = 32'h8829;
  int              error_count = 0;
  int              issued = 0;
  int              results_checked = 0;
  logic [XLEN-1:0] model_regs [0:NUM_REGS-1];
  wb_t             pending [$];  // Issued instructions not yet handed to execute.
  wb_t             head_last;
  wb_t             exp_head;     // Result expected on o_wb in the current cycle.
  logic            exp_wb_valid;
  logic            hs_last;
  logic            busy;
  logic            seen_strobe;
  logic [XLEN-1:0] pc;
  logic            head_is_alu;

  core_top i_dut (
    .clk          (clk),
    .rst          (rst),
    .i_fetch_req  (i_fetch_req),
    .i_fetch_pc   (i_fetch_pc),
    .i_fetch_inst (i_fetch_inst),
    .i_stall      (i_stall),
    .o_busy       (o_busy),
    .o_wb_valid   (o_wb_valid),
    .o_wb         (o_wb)
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic log_failure(input string msg);
    error_count++;
    $display("FAILED at time %0t: %s", $time, msg);
  endtask

  // Computes the expected writeback of one instruction from the RV64I rules.
  function automatic wb_t reference_result(input logic [XLEN-1:0] cur_pc,
                                           input logic [ILEN-1:0] inst);
    wb_t             res;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    logic [2:0]      f3;
    logic [6:0]      f7;
    logic            legal;
    a       = model_regs[inst[19:15]];
    b       = model_regs[inst[24:20]];
    imm_i   = {{52{inst[31]}}, inst[31:20]};
    imm_u   = {{32{inst[31]}}, inst[31:12], 12'h000};
    imm_j   = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    f3      = inst[14:12];
    f7      = inst[31:25];
    legal   = 1'b1;
    res     = '0;
    res.pc  = cur_pc;
    res.inst = inst;
    res.rd  = inst[11:7];
    res.next_pc = cur_pc + 64'd4;
    case (inst[6:0])
      OPC_OP: begin
        if (f7 == 7'h20 && f3 == 3'd0) begin
          res.data = a - b;
        end else if (f7 != 7'h00) begin
          legal = 1'b0;
        end else begin
          case (f3)
            3'd0:    res.data = a + b;
            3'd1:    res.data = a << b[5:0];
            3'd4:    res.data = a ^ b;
            3'd5:    res.data = a >> b[5:0];
            3'd6:    res.data = a | b;
            3'd7:    res.data = a & b;
            default: legal = 1'b0;
          endcase
        end
      end
      OPC_OP_IMM: begin
        case (f3)
          3'd0:    res.data = a + imm_i;
          3'd4:    res.data = a ^ imm_i;
          3'd6:    res.data = a | imm_i;
          3'd7:    res.data = a & imm_i;
          3'd1: begin
            if (inst[31:26] == 6'd0) begin
              res.data = a << inst[25:20];
            end else begin
              legal = 1'b0;
            end
          end
          3'd5: begin
            if (inst[31:26] == 6'd0) begin
              res.data = a >> inst[25:20];
            end else begin
              legal = 1'b0;
            end
          end
          default: legal = 1'b0;
        endcase
      end
      OPC_LUI:   res.data = imm_u;
      OPC_AUIPC: res.data = cur_pc + imm_u;
      OPC_JAL: begin
        res.data    = cur_pc + 64'd4;
        res.next_pc = cur_pc + imm_j;
      end
      default: legal = 1'b0;
    endcase
    res.wen     = legal;
    res.illegal = !legal;
    return res;
  endfunction

  // Uses only x0 to x3 so that dependencies and x0 targets are frequent.
  function automatic logic [ILEN-1:0] random_inst();
    logic [31:0] bits;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic [6:0]  opc;
    bits = $random(seed);
    rd   = {3'b000, bits[1:0]};
    rs1  = {3'b000, bits[3:2]};
    rs2  = {3'b000, bits[5:4]};
    f3   = bits[8:6];
    imm  = bits[31:20];
    case (int'(bits[19:16]))
      0, 1, 2, 3: return {(bits[9] ? 7'h20 : 7'h00), rs2, rs1, f3, rd, OPC_OP};
      4, 5, 6, 7: begin
        if (f3 == 3'd1 || f3 == 3'd5) begin
          imm = {(bits[10] ? 6'b010000 : 6'b000000), bits[25:20]};  // srai is not supported.
        end
        return {imm, rs1, f3, rd, OPC_OP_IMM};
      end
      8:  return {bits[31:12], rd, OPC_LUI};
      9:  return {bits[31:12], rd, OPC_AUIPC};
      10: return {bits[31:12], rd, OPC_JAL};
      default: begin
        case (bits[11:10])
          2'd0:    opc = 7'b0000011;
          2'd1:    opc = 7'b0100011;
          2'd2:    opc = 7'b1100011;
          default: opc = 7'b0011011;
        endcase
        return {bits[31:12], rd, opc};
      end
    endcase
  endfunction

  // Drives one clock of stimulus and tracks when each result must appear.
  task automatic drive_cycle(input logic do_fetch, input logic [ILEN-1:0] inst,
                             input logic stall);
    wb_t  predicted;
    logic hs;
    @(posedge clk);
    exp_wb_valid <= hs_last;
    if (hs_last) begin
      exp_head <= head_last;
      results_checked++;
    end
    hs      = busy && !stall;
    hs_last = hs;
    if (hs) head_last = pending.pop_front();
    if (do_fetch) begin
      predicted = reference_result(pc, inst);
      if (predicted.wen && predicted.rd != '0) model_regs[predicted.rd] = predicted.data;
      pending.push_back(predicted);
      seen_strobe <= 1'b1;
      issued++;
    end
    i_fetch_req  <= do_fetch;
    i_fetch_pc   <= pc;
    i_fetch_inst <= inst;
    i_stall      <= stall;
    if (do_fetch) pc = predicted.next_pc;
    busy = do_fetch ? 1'b1 : (hs ? 1'b0 : busy);
  endtask

  initial begin : stimulus
    logic [31:0] bits;
    logic        stall;
    rst          <= 1'b1;
    i_fetch_req  <= 1'b0;
    i_fetch_pc   <= '0;
    i_fetch_inst <= '0;
    i_stall      <= 1'b0;
    exp_head     <= '0;
    head_last    = '0;
    exp_wb_valid <= 1'b0;
    hs_last      = 1'b0;
    busy         = 1'b0;
    seen_strobe  <= 1'b0;
    pc           = 64'h0000_0000_8000_0000;
    for (int i = 0; i < NUM_REGS; i++) model_regs[i] = '0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    repeat (4) drive_cycle(1'b0, '0, 1'b0);
    // Dependent chain where each strobe lands on the previous handshake edge.
    drive_cycle(1'b1, {12'd5, 5'd0, 3'd0, 5'd1, OPC_OP_IMM}, 1'b0);
    drive_cycle(1'b1, {12'hffd, 5'd1, 3'd0, 5'd1, OPC_OP_IMM}, 1'b0);
    drive_cycle(1'b1, {7'h00, 5'd1, 5'd1, 3'd0, 5'd2, OPC_OP}, 1'b0);
    drive_cycle(1'b1, {7'h20, 5'd1, 5'd2, 3'd0, 5'd3, OPC_OP}, 1'b0);
    drive_cycle(1'b1, {6'h00, 6'd40, 5'd3, 3'd1, 5'd3, OPC_OP_IMM}, 1'b0);
    while (issued < NUM_INSTS) begin
      bits  = $random(seed);
      stall = (bits[2:0] < 3'd2);
      drive_cycle((bits[4:3] != 2'd0) && (!busy || !stall), random_inst(), stall);
    end
    while (busy || hs_last || pending.size() != 0) drive_cycle(1'b0, '0, 1'b0);
    repeat (3) drive_cycle(1'b0, '0, 1'b0);
    $display("Summary: %0d instructions issued, %0d results checked, %0d errors",
             issued, results_checked, error_count);
    if (error_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    #(LIMIT_CYCLES * CLK_PERIOD);
    $display("Timeout: the run did not complete within %0d cycles.", LIMIT_CYCLES);
    $display("Summary: %0d instructions issued, %0d results checked, %0d errors",
             issued, results_checked, error_count);
    $display("STATUS: FAIL");
    $finish;
  end

  assign head_is_alu = (exp_head.inst[6:0] == OPC_OP) || (exp_head.inst[6:0] == OPC_OP_IMM);

  a_idle_after_reset: assert property (@(posedge clk) disable iff (rst)
    !seen_strobe |-> (!o_busy && !o_wb_valid))
    else log_failure("busy or result valid before the first fetch strobe");

  a_alu_result: assert property (@(posedge clk) disable iff (rst)
    (o_wb_valid && !exp_head.illegal && head_is_alu) |-> (o_wb == exp_head))
    else log_failure($sformatf("ALU result for pc %h: expected %h, got %h",
                               $sampled(exp_head.pc), $sampled(exp_head.data),
                               $sampled(o_wb.data)));

  a_upper_result: assert property (@(posedge clk) disable iff (rst)
    (o_wb_valid && !exp_head.illegal && !head_is_alu) |-> (o_wb == exp_head))
    else log_failure($sformatf("pc relative result for pc %h: expected %h/%h, got %h/%h",
                               $sampled(exp_head.pc), $sampled(exp_head.data),
                               $sampled(exp_head.next_pc), $sampled(o_wb.data),
                               $sampled(o_wb.next_pc)));

  a_illegal_result: assert property (@(posedge clk) disable iff (rst)
    (o_wb_valid && exp_head.illegal) |-> (o_wb.illegal && !o_wb.wen &&
      o_wb.pc == exp_head.pc && o_wb.inst == exp_head.inst &&
      o_wb.next_pc == exp_head.next_pc))
    else log_failure($sformatf("illegal instruction %h not reported as expected",
                               $sampled(exp_head.inst)));

  a_wb_when_expected: assert property (@(posedge clk) disable iff (rst)
    o_wb_valid == exp_wb_valid)
    else log_failure($sformatf("result valid is %b, expected %b",
                               $sampled(o_wb_valid), $sampled(exp_wb_valid)));

  a_fetch_to_wb: assert property (@(posedge clk) disable iff (rst)
    ($past(i_fetch_req, 2) && !$past(i_stall)) |-> o_wb_valid)
    else log_failure("no result two cycles after an unstalled fetch strobe");

  a_stall_no_wb: assert property (@(posedge clk) disable iff (rst)
    i_stall |=> !o_wb_valid)
    else log_failure("result valid after a stalled cycle");

  a_stall_busy: assert property (@(posedge clk) disable iff (rst)
    (o_busy && i_stall) |=> o_busy)
    else log_failure("busy dropped during a stall");

endmodule

`default_nettype wire

// ==== project.f ====
source/rv_pkg.sv
source/id_decoder.sv
source/id_stage.sv
source/reg_file.sv
source/ex_stage.sv
source/core_top.sv
verification/tb_core.sv
